//--- sources.f
+incdir+source
source/axil_apb_pkg.sv
source/apb_if.sv
source/rr_arbiter.sv
source/axil2apb_bridge.sv
source/apb_reg_bank.sv
source/axil_apb_top.sv
testbench/tb_axil_apb.sv

//--- Makefile
# Verilator build and run of the AXI4-Lite to APB testbench
# Override any variable on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_axil_apb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

SOURCES := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_axil_apb.sv
// Directed testbench for the AXI4-Lite to APB bridge and its register bank
// Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
// A shadow copy of the bank predicts read data and responses
`timescale 1ns/1ps
`include "axil_apb_config.svh"

module tb_axil_apb import axil_apb_pkg::*; ();

  localparam int W            = `APB_WAIT_STATES;
  localparam int AW           = `AXIL_ADDR_WIDTH;
  localparam int DW           = `AXIL_DATA_WIDTH;
  localparam int NUM_TRANS    = 80;
  localparam int LIMIT_CYCLES = NUM_TRANS * (W + 3 + 8) + 200;

  logic            clk;
  logic            reset;
  logic [AW-1:0]   awaddr;
  prot_t           awprot;
  logic            awvalid;
  logic            awready;
  logic [DW-1:0]   wdata;
  logic [DW/8-1:0] wstrb;
  logic            wvalid;
  logic            wready;
  axi_resp_t       bresp;
  logic            bvalid;
  logic            bready;
  logic [AW-1:0]   araddr;
  prot_t           arprot;
  logic            arvalid;
  logic            arready;
  logic [DW-1:0]   rdata;
  axi_resp_t       rresp;
  logic            rvalid;
  logic            rready;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;
  int          last_accept;
  int          last_taken;
  logic        prio_write;
  logic [31:0] lcg_state;
  logic [31:0] shadow [`REG_COUNT];

  axil_apb_top UUT (.*);

  // --------------------
  // Clock and watchdog
  // --------------------
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycle index, read on the falling edge
  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: no end of the tests after %0d clock cycles", LIMIT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // Numerical Recipes constants
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [AW-1:0] word_addr(input int idx);
    return AW'(idx * 4);
  endfunction

  // Error rules of the bank: range, read-only ID word, protected block
  function automatic logic predict_err(input logic [AW-1:0] addr, input logic wr,
                                       input prot_t prot);
    int idx;
    idx = int'(addr[AW-1:2]);
    if (idx >= `REG_COUNT) return 1'b1;
    if (wr && idx == `REG_COUNT - 1) return 1'b1;
    if (idx >= `REG_PROT_FIRST && idx <= `REG_COUNT - 2 && !prot[0]) return 1'b1;
    return 1'b0;
  endfunction

  function automatic logic [31:0] predict_rdata(input logic [AW-1:0] addr, input prot_t prot);
    int idx;
    idx = int'(addr[AW-1:2]);
    if (predict_err(addr, 1'b0, prot)) return 32'h0;
    if (idx == `REG_COUNT - 1) return `REG_ID_VALUE;
    return shadow[idx];
  endfunction

  task automatic update_shadow(input logic [AW-1:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
    int idx;
    idx = int'(addr[AW-1:2]);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
    end
  endtask

  // --------------------
  // AXI4-Lite driver
  // --------------------
  task automatic start_write(input logic [AW-1:0] addr, input prot_t prot,
                             input logic [31:0] data, input logic [3:0] strb);
    awaddr  = addr;
    awprot  = prot;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
  endtask

  task automatic start_read(input logic [AW-1:0] addr, input prot_t prot);
    araddr  = addr;
    arprot  = prot;
    arvalid = 1'b1;
  endtask

  // Called on a falling edge; a read grant while waiting means the order was wrong
  task automatic write_accept(input string name);
    while (!(awready && wready)) begin
      check({name, " read granted first"}, 32'h0, 32'(arready));
      @(negedge clk);
    end
    last_accept = cycle;
    prio_write = !prio_write;
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic read_accept(input string name);
    while (!arready) begin
      check({name, " write granted first"}, 32'h0, 32'(awready));
      @(negedge clk);
    end
    last_accept = cycle;
    prio_write = !prio_write;
    @(posedge clk);
    #1;
    arvalid = 1'b0;
  endtask

  // bready stays low for hold cycles after bvalid, all readies must stay low
  task automatic write_resp(input string name, input int hold,
                            output axi_resp_t resp, output int seen);
    bready = (hold == 0);
    @(negedge clk);
    while (!bvalid) begin
      check({name, " ready while busy"}, 32'h0, 32'({awready, wready, arready}));
      @(negedge clk);
    end
    seen = cycle;
    resp = bresp;
    for (int i = 0; i < hold; i++) begin
      check({name, " bvalid held"}, 32'h1, 32'(bvalid));
      check({name, " bresp held"}, 32'(resp), 32'(bresp));
      check({name, " ready under back-pressure"}, 32'h0, 32'({awready, wready, arready}));
      @(posedge clk);
      #1;
      bready = (i == hold - 1);
      @(negedge clk);
    end
    check({name, " ready at response"}, 32'h0, 32'({awready, wready, arready}));
    last_taken = cycle;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_resp(input string name, output axi_resp_t resp,
                           output logic [31:0] data, output int seen);
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) begin
      check({name, " ready while busy"}, 32'h0, 32'({awready, wready, arready}));
      @(negedge clk);
    end
    seen = cycle;
    resp = rresp;
    data = rdata;
    last_taken = cycle;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // Write already presented by start_write, run to the response and check it
  task automatic write_finish(input string name, input logic [AW-1:0] addr, input prot_t prot,
                              input logic [31:0] data, input logic [3:0] strb, input int hold);
    axi_resp_t resp;
    int        seen;
    logic      err;
    err = predict_err(addr, 1'b1, prot);
    @(negedge clk);
    write_accept(name);
    write_resp(name, hold, resp, seen);
    check({name, " bresp"}, 32'(err ? SLVERR : OKAY), 32'(resp));
    check({name, " latency"}, W + 3, seen - last_accept);
    if (!err) update_shadow(addr, data, strb);
  endtask

  task automatic read_finish(input string name, input logic [AW-1:0] addr, input prot_t prot);
    axi_resp_t   resp;
    logic [31:0] data;
    int          seen;
    logic        err;
    logic [31:0] expected;
    err = predict_err(addr, 1'b0, prot);
    expected = predict_rdata(addr, prot);
    @(negedge clk);
    read_accept(name);
    read_resp(name, resp, data, seen);
    check({name, " rresp"}, 32'(err ? SLVERR : OKAY), 32'(resp));
    check({name, " rdata"}, expected, data);
    check({name, " latency"}, W + 3, seen - last_accept);
  endtask

  task automatic axil_write(input string name, input logic [AW-1:0] addr, input prot_t prot,
                            input logic [31:0] data, input logic [3:0] strb);
    start_write(addr, prot, data, strb);
    write_finish(name, addr, prot, data, strb, 0);
  endtask

  task automatic axil_read(input string name, input logic [AW-1:0] addr, input prot_t prot);
    start_read(addr, prot);
    read_finish(name, addr, prot);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_full_word();
    for (int i = 0; i < 8; i++) begin
      axil_write($sformatf("full write %0d", i), word_addr(i), 3'b000, next_random(), 4'hF);
    end
    for (int i = 0; i < 8; i++) begin
      axil_read($sformatf("full read %0d", i), word_addr(i), 3'b000);
    end
  endtask

  task automatic test_partial_strobes();
    logic [3:0] strbs [6] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0101, 4'b0000};
    for (int i = 0; i < 6; i++) begin
      axil_write($sformatf("strobe write %0d", i), word_addr(i), 3'b000, next_random(), strbs[i]);
      axil_read($sformatf("strobe read %0d", i), word_addr(i), 3'b000);
    end
  endtask

  task automatic test_address_errors();
    axil_write("range write", word_addr(`REG_COUNT), 3'b001, next_random(), 4'hF);
    axil_read("range read", word_addr(`REG_COUNT + 3), 3'b001);
    axil_read("range read top", {AW{1'b1}}, 3'b001);
    axil_write("id write", word_addr(`REG_COUNT - 1), 3'b001, next_random(), 4'hF);
    axil_read("id read", word_addr(`REG_COUNT - 1), 3'b000);
  endtask

  // User access must fail and leave the privileged value intact
  task automatic test_protected();
    for (int i = `REG_PROT_FIRST; i <= `REG_COUNT - 2; i++) begin
      axil_write($sformatf("priv write %0d", i), word_addr(i), 3'b001, next_random(), 4'hF);
      axil_write($sformatf("user write %0d", i), word_addr(i), 3'b000, next_random(), 4'hF);
      axil_read($sformatf("user read %0d", i), word_addr(i), 3'b000);
      axil_read($sformatf("priv read %0d", i), word_addr(i), 3'b001);
    end
  endtask

  // Same word on both channels so the grant order shows in the read data
  task automatic test_simultaneous();
    logic [31:0] data;
    int          taken;
    string       name;
    for (int k = 0; k < 4; k++) begin
      // An extra grant on odd rounds so both grant orders come up
      if (k % 2 == 1) axil_read($sformatf("flip read %0d", k), word_addr(7), 3'b000);
      name = $sformatf("simul %0d", k);
      data = next_random();
      start_write(word_addr(k), 3'b000, data, 4'hF);
      start_read(word_addr(k), 3'b000);
      if (prio_write) begin
        write_finish({name, " write"}, word_addr(k), 3'b000, data, 4'hF, 0);
        taken = last_taken;
        read_finish({name, " read"}, word_addr(k), 3'b000);
      end else begin
        read_finish({name, " read"}, word_addr(k), 3'b000);
        taken = last_taken;
        write_finish({name, " write"}, word_addr(k), 3'b000, data, 4'hF, 0);
      end
      check({name, " second handshake cycle"}, taken + 1, last_accept);
    end
  endtask

  task automatic test_backpressure();
    logic [31:0] data;
    int          taken;
    // Write must win the tie so that the read waits behind it
    if (!prio_write) axil_read("bp flip read", word_addr(0), 3'b000);
    data = next_random();
    start_read(word_addr(2), 3'b000);
    start_write(word_addr(2), 3'b000, data, 4'hF);
    write_finish("bp write", word_addr(2), 3'b000, data, 4'hF, 5);
    taken = last_taken;
    read_finish("bp read", word_addr(2), 3'b000);
    check("bp read handshake cycle", taken + 1, last_accept);
    // Error response under back-pressure too
    data = next_random();
    start_write(word_addr(`REG_COUNT - 1), 3'b001, data, 4'hF);
    write_finish("bp id write", word_addr(`REG_COUNT - 1), 3'b001, data, 4'hF, 3);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    reset   = 1'b1;
    awaddr  = '0;
    awprot  = 3'b000;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = 3'b000;
    arvalid = 1'b0;
    rready  = 1'b0;
    lcg_state = 32'd92;
    prio_write = 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) shadow[i] = 32'h0;

    repeat (5) @(posedge clk);
    #1;
    check("reset outputs", 32'h0, 32'({awready, wready, arready, bvalid, rvalid}));
    reset = 1'b0;

    test_full_word();
    test_partial_strobes();
    test_address_errors();
    test_protected();
    test_simultaneous();
    test_backpressure();

    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- source/axil_apb_top.sv
// AXI4-Lite slave ports in front of one APB register bank
// One transaction at a time with W+3 cycles from handshake to response
`timescale 1ns/1ps
`include "axil_apb_config.svh"

module axil_apb_top import axil_apb_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,

  // Write address and data
  input  logic [`AXIL_ADDR_WIDTH-1:0]   awaddr,
  input  prot_t                         awprot,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`AXIL_DATA_WIDTH-1:0]   wdata,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,

  // Write response
  output axi_resp_t                     bresp,
  output logic                          bvalid,
  input  logic                          bready,

  // Read address and data
  input  logic [`AXIL_ADDR_WIDTH-1:0]   araddr,
  input  prot_t                         arprot,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`AXIL_DATA_WIDTH-1:0]   rdata,
  output axi_resp_t                     rresp,
  output logic                          rvalid,
  input  logic                          rready
);

  // Internal APB between bridge and bank
  apb_if apb_bus ();

  axil2apb_bridge u_bridge (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .apb     (apb_bus.master)
  );

  apb_reg_bank u_bank (
    .clk   (clk),
    .reset (reset),
    .apb   (apb_bus.slave)
  );

endmodule

//--- source/apb_reg_bank.sv
// APB register bank of REG_COUNT words with byte strobes and wait states
// Last word is read-only and returns REG_ID_VALUE
// Upper protected block needs the privileged bit in pprot
`timescale 1ns/1ps
`include "axil_apb_config.svh"

module apb_reg_bank import axil_apb_pkg::*; (
  input  logic clk,
  input  logic reset,
  apb_if.slave apb
);

  localparam int DW    = `AXIL_DATA_WIDTH;
  localparam int AW    = `AXIL_ADDR_WIDTH;
  localparam int IDX_W = $clog2(`REG_COUNT);
  localparam int CNT_W = ($clog2(`APB_WAIT_STATES + 1) > 0) ?
                         $clog2(`APB_WAIT_STATES + 1) : 1;

  // Writable words only since the ID word is a constant
  logic [DW-1:0]    regs [`REG_COUNT-1];
  logic [CNT_W-1:0] wait_cnt_q;
  logic [AW-3:0]    word_idx;
  logic [IDX_W-1:0] word_sel;
  logic             in_range;
  logic             is_id;
  logic             is_prot;
  logic             err;
  logic             access;
  logic             done;

  // --------------------
  // Wait states
  // --------------------
  assign access    = apb.psel && apb.penable;
  assign apb.pready = (wait_cnt_q == CNT_W'(`APB_WAIT_STATES));
  assign done      = access && apb.pready;

  // Counts ACCESS cycles and clears when the transfer completes
  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt_q <= '0;
    end else if (done) begin
      wait_cnt_q <= '0;
    end else if (access) begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  // --------------------
  // Decode
  // --------------------
  // Word addressing so the byte offset bits are ignored
  assign word_idx = apb.paddr[AW-1:2];
  assign word_sel = word_idx[IDX_W-1:0];
  assign in_range = (word_idx < (AW-2)'(`REG_COUNT));
  assign is_id    = (word_idx == (AW-2)'(`REG_COUNT - 1));
  assign is_prot  = (word_idx >= (AW-2)'(`REG_PROT_FIRST)) &&
                    (word_idx <= (AW-2)'(`REG_COUNT - 2));

  assign err = !in_range
            || (apb.pwrite && is_id)
            || (is_prot && !apb.pprot[PROT_PRIV_BIT]);

  assign apb.pslverr = err;

  // Zero on error and on writes
  always_comb begin
    apb.prdata = '0;
    if (!err && !apb.pwrite) begin
      apb.prdata = is_id ? DW'(`REG_ID_VALUE) : regs[word_sel];
    end
  end

  // --------------------
  // Storage
  // --------------------
  // Only bytes with their strobe set are updated
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (done && apb.pwrite && !err) begin
      for (int b = 0; b < DW / 8; b++) begin
        if (apb.pstrb[b]) begin
          regs[word_sel][8*b +: 8] <= apb.pwdata[8*b +: 8];
        end
      end
    end
  end

  // Master protocol check on the setup to access order
  a_penable_after_setup: assert property (
    @(posedge clk) disable iff (reset)
    $rose(apb.penable) |-> (apb.psel && $past(apb.psel && !apb.penable))
  );

endmodule

//--- source/axil2apb_bridge.sv
// AXI4-Lite slave to APB master with one transaction in flight
// No bursts, IDs or outstanding requests
// Read and write requests in IDLE are arbitrated round-robin
`timescale 1ns/1ps
`include "axil_apb_config.svh"

module axil2apb_bridge import axil_apb_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,

  // Write address and data
  input  logic [`AXIL_ADDR_WIDTH-1:0]   awaddr,
  input  prot_t                         awprot,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`AXIL_DATA_WIDTH-1:0]   wdata,
  input  logic [`AXIL_DATA_WIDTH/8-1:0] wstrb,
  input  logic                          wvalid,
  output logic                          wready,

  // Write response
  output axi_resp_t                     bresp,
  output logic                          bvalid,
  input  logic                          bready,

  // Read address and data
  input  logic [`AXIL_ADDR_WIDTH-1:0]   araddr,
  input  prot_t                         arprot,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`AXIL_DATA_WIDTH-1:0]   rdata,
  output axi_resp_t                     rresp,
  output logic                          rvalid,
  input  logic                          rready,

  apb_if.master                         apb
);

  bridge_state_t state_q, state_d;

  // Transaction captured at the handshake
  logic [`AXIL_ADDR_WIDTH-1:0]   addr_q;
  logic [`AXIL_DATA_WIDTH-1:0]   data_q;
  logic [`AXIL_DATA_WIDTH/8-1:0] strb_q;
  prot_t                         prot_q;
  logic                          write_q;

  // Completion captured from the bank
  logic                          err_q;
  logic [`AXIL_DATA_WIDTH-1:0]   rdata_q;

  logic write_req, read_req;
  logic write_grant, read_grant;
  logic any_grant;
  logic access_done;

  // --------------------
  // Arbitration
  // --------------------
  // Requests only count while idle
  assign write_req = awvalid && wvalid && (state_q == IDLE);
  assign read_req  = arvalid && (state_q == IDLE);
  assign any_grant = write_grant || read_grant;

  // Bit 1 is the write side so write wins the first tie after reset
  rr_arbiter u_arb (
    .clk     (clk),
    .reset   (reset),
    .request ({write_req, read_req}),
    .grant   ({write_grant, read_grant})
  );

  // Payload registers load on the winning request
  always_ff @(posedge clk) begin
    if (any_grant) begin
      addr_q  <= write_grant ? awaddr : araddr;
      prot_q  <= write_grant ? awprot : arprot;
      data_q  <= wdata;
      strb_q  <= wstrb;
      write_q <= write_grant;
    end
  end

  // --------------------
  // APB FSM
  // --------------------
  assign access_done = (state_q == ACCESS) && apb.pready;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:   if (any_grant) state_d = SETUP;
      SETUP:  state_d = ACCESS;
      ACCESS: if (apb.pready) state_d = RESP;
      RESP: begin
        // Leave on the edge where the master takes the response
        if ((write_q && bready) || (!write_q && rready)) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // prdata and pslverr are only meaningful on the completing cycle
  always_ff @(posedge clk) begin
    if (access_done) begin
      err_q   <= apb.pslverr;
      rdata_q <= apb.prdata;
    end
  end

  // --------------------
  // AXI outputs
  // --------------------
  // Handshake is combinational with the grant
  assign awready = write_grant;
  assign wready  = write_grant;
  assign arready = read_grant;

  assign bvalid = (state_q == RESP) && write_q;
  assign rvalid = (state_q == RESP) && !write_q;
  assign bresp  = err_q ? SLVERR : OKAY;
  assign rresp  = err_q ? SLVERR : OKAY;
  assign rdata  = rdata_q;

  // APB request side straight from the captured transaction
  assign apb.psel    = (state_q == SETUP) || (state_q == ACCESS);
  assign apb.penable = (state_q == ACCESS);
  assign apb.paddr   = addr_q;
  assign apb.pwrite  = write_q;
  assign apb.pprot   = prot_q;
  assign apb.pstrb   = strb_q;
  assign apb.pwdata  = data_q;

  // --------------------
  // Checks
  // --------------------
  a_state_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(state_q)
  );

  // No handshake while an APB transfer or a response is in progress
  a_ready_only_idle: assert property (
    @(posedge clk) disable iff (reset)
    (awready || wready || arready) |-> !(apb.psel || bvalid || rvalid)
  );

  // Responses stay put under back-pressure
  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    (bvalid && !bready) |=> (bvalid && $stable(bresp))
  );

  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    (rvalid && !rready) |=> (rvalid && $stable(rresp) && $stable(rdata))
  );

endmodule

//--- source/rr_arbiter.sv
// Round-robin arbiter for exactly two requesters
// Grant is combinational from request and the registered pointer
`timescale 1ns/1ps

module rr_arbiter (
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] request,
  output logic [1:0] grant
);

  // Pointer value 1 gives requester 1 priority
  logic prio_q;

  // --------------------
  // Grant logic
  // --------------------
  // Lone requester always wins
  // On a tie the pointer decides
  always_comb begin
    grant[1] = request[1] && (!request[0] || prio_q);
    grant[0] = request[0] && (!request[1] || !prio_q);
  end

  // --------------------
  // Priority pointer
  // --------------------
  // Starts at requester 1 and flips on every grant
  always_ff @(posedge clk) begin
    if (reset) begin
      prio_q <= 1'b1;
    end else if (|grant) begin
      prio_q <= !prio_q;
    end
  end

  // Never two winners and never a grant without its request
  a_grant_valid: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(grant) && ((grant & ~request) == 2'b00)
  );

endmodule

//--- source/apb_if.sv
// APB bus between the bridge and a single slave
// No decoder so psel goes straight to the one bank
`timescale 1ns/1ps
`include "axil_apb_config.svh"

interface apb_if import axil_apb_pkg::*; ();

  // Request side driven by the bridge
  logic [`AXIL_ADDR_WIDTH-1:0]   paddr;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  prot_t                         pprot;
  logic [`AXIL_DATA_WIDTH/8-1:0] pstrb;
  logic [`AXIL_DATA_WIDTH-1:0]   pwdata;

  // Completion side driven by the bank
  logic [`AXIL_DATA_WIDTH-1:0]   prdata;
  logic                          pready;
  logic                          pslverr;

  modport master (
    output paddr, psel, penable, pwrite, pprot, pstrb, pwdata,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pprot, pstrb, pwdata,
    output prdata, pready, pslverr
  );

endinterface

//--- source/axil_apb_pkg.sv
// Types shared by the AXI4-Lite to APB bridge and the register bank
// Response encoding follows AXI4 with only OKAY and SLVERR in use
package axil_apb_pkg;

  // --------------------
  // AXI response
  // --------------------
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  // --------------------
  // Protection
  // --------------------
  // Same bit layout on AXI prot and APB pprot
  typedef logic [2:0] prot_t;

  // Bit 0 set marks a privileged access
  localparam int PROT_PRIV_BIT = 0;

  // --------------------
  // Bridge FSM
  // --------------------
  // One-hot so that every state is a single flop
  typedef enum logic [3:0] {
    IDLE   = 4'b0001,
    SETUP  = 4'b0010,
    ACCESS = 4'b0100,
    RESP   = 4'b1000
  } bridge_state_t;

endpackage

//--- source/axil_apb_config.svh
// Build-time settings shared by the bridge, the APB bus and the register bank
// Address width must be at least 12 and data width at least 32
// The last word of the bank is read-only and returns the identification value
`ifndef AXIL_APB_CONFIG_SVH
`define AXIL_APB_CONFIG_SVH

// Bus widths
`define AXIL_ADDR_WIDTH 12
`define AXIL_DATA_WIDTH 32

// Access cycles with pready low before the bank answers
`define APB_WAIT_STATES 1

// Number of 32-bit words in the bank
`define REG_COUNT 16

// Constant read back from word REG_COUNT-1
`define REG_ID_VALUE 32'hA4B0_0C17

// First word of the protected block that ends at word REG_COUNT-2
`define REG_PROT_FIRST 8

`endif
